/* Makefile */
# Verilator build and run for the pagerank scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_pagerank_scheduler
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
pagerank_pkg.sv
host_regs.sv
r_loader.sv
g_loader.sv
mem_arbiter.sv
pagerank_scheduler.sv
pagerank_scheduler_asserts.sv
tb_pagerank_scheduler.sv

/* g_loader.sv */
/*
  matrix column loader
  reads size columns of G, one word each, keeping the latest in g_col
*/
`timescale 1ns/100ps

module g_loader import pagerank_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] base_g,
  input  logic [31:0] size,

  // toward the arbiter
  output logic        busy,
  output logic        req_val,
  output logic [31:0] req_addr,
  input  logic        req_rdy,
  input  logic        resp_val,
  input  mem_word_u   resp_data,

  output mem_word_u   g_col
);

  logic        waiting;
  logic [31:0] col_cnt;
  logic        cols_done;

  // all columns fetched, also true at once for size 0
  assign cols_done = (col_cnt == size);

  assign req_val  = busy && !waiting && !cols_done;
  assign req_addr = base_g + col_cnt * 32'(g_column_stride);

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      waiting <= 1'b0;
      col_cnt <= 32'd0;
    end else if (start && !busy) begin
      busy    <= 1'b1;
      waiting <= 1'b0;
      col_cnt <= 32'd0;
    end else if (busy) begin
      if (!waiting && cols_done) begin
        // empty run, no request at all
        busy <= 1'b0;
      end else if (!waiting && req_rdy) begin
        waiting <= 1'b1;
      end else if (waiting && resp_val) begin
        waiting <= 1'b0;
        col_cnt <= col_cnt + 32'd1;
        // column size-1 just came back
        if (col_cnt + 32'd1 == size)
          busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // column register
  // ----------------------------------------

  // keeps the previous column when nothing is fetched
  always_ff @(posedge clk) begin
    if (waiting && resp_val) begin
      for (int i = 0; i < entries_per_word; i++) begin
        g_col.entries[i] <= resp_data.entries[i];
      end
    end
  end

endmodule

/* host_regs.sv */
/*
  host register block for the pagerank scheduler
  zero latency request decode, config registers, go pulse and readback
*/
`timescale 1ns/100ps

module host_regs import pagerank_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // host request side
  input  host_req_t  pr_req,
  input  logic       pr_req_val,
  output logic       pr_req_rdy,

  // host response side
  output host_resp_t pr_resp,
  output logic       pr_resp_val,
  input  logic       pr_resp_rdy,

  // loader status and banks
  input  logic       r_busy,
  input  logic       g_busy,
  input  r_vec_t     r_vec,
  input  mem_word_u  g_col,

  output sched_cfg_t cfg,
  output logic       start
);

  logic        idle;
  logic        req_go;
  logic        wr_go;
  logic [31:0] rd_data;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // host only served while both loaders rest
  assign idle = !r_busy && !g_busy;

  // request and response complete together
  assign pr_req_rdy  = idle && pr_resp_rdy;
  assign pr_resp_val = idle && pr_req_val;

  assign req_go = pr_req_val && pr_req_rdy;
  assign wr_go  = req_go && pr_req.write;

  // one cycle go pulse, loaders see it at the next edge
  assign start = wr_go && (pr_req.addr == addr_go);

  // ----------------------------------------
  // configuration registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr_go) begin
      case (pr_req.addr)
        addr_base_g: cfg.base_g <= pr_req.data;
        addr_base_r: cfg.base_r <= pr_req.data;
        addr_size:   cfg.size   <= pr_req.data;
        default:     cfg        <= cfg;
      endcase
    end
  end

  // ----------------------------------------
  // readback
  // ----------------------------------------

  always_comb begin
    case (pr_req.addr)
      addr_base_g: rd_data = cfg.base_g;
      addr_base_r: rd_data = cfg.base_r;
      addr_size:   rd_data = cfg.size;
      // R words, low half holds entries 0 to 3
      addr_r_lo:   rd_data = r_vec[entries_per_word-1:0];
      addr_r_hi:   rd_data = r_vec[n-1:entries_per_word];
      addr_g_col:  rd_data = g_col.word;
      default:     rd_data = 32'd0;
    endcase
  end

  // writes answer with zero data
  assign pr_resp.write = pr_req.write;
  assign pr_resp.data  = pr_req.write ? 32'd0 : rd_data;

endmodule

/* mem_arbiter.sv */
/*
  memory port arbiter for the R and G loaders
  fixed R priority, one request in flight, response routed by owner
*/
`timescale 1ns/100ps

module mem_arbiter import pagerank_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // R loader
  input  logic        r_req_val,
  input  logic [31:0] r_req_addr,
  output logic        r_req_rdy,
  output logic        r_resp_val,

  // G loader
  input  logic        g_req_val,
  input  logic [31:0] g_req_addr,
  output logic        g_req_rdy,
  output logic        g_resp_val,

  // response word, shared by both loaders
  output mem_word_u   resp_data,

  // memory port
  output logic        mem_req_val,
  output logic [31:0] mem_req_addr,
  input  logic        mem_req_rdy,
  input  mem_word_u   mem_resp_data,
  input  logic        mem_resp_val,
  output logic        mem_resp_rdy
);

  logic outstanding;
  // owner, 0 for R and 1 for G
  logic owner;
  // request shown to memory but not yet taken
  logic locked;
  logic sel_g;
  logic mem_req_go;

  // ----------------------------------------
  // grant
  // ----------------------------------------

  // R wins unless a stalled G request must be held
  assign sel_g = locked ? owner : !r_req_val;

  assign mem_req_val  = !outstanding && (sel_g ? g_req_val : r_req_val);
  assign mem_req_addr = sel_g ? g_req_addr : r_req_addr;

  assign r_req_rdy = !outstanding && !sel_g && mem_req_rdy;
  assign g_req_rdy = !outstanding && sel_g && mem_req_rdy;

  assign mem_req_go = mem_req_val && mem_req_rdy;

  // ----------------------------------------
  // response routing
  // ----------------------------------------

  assign mem_resp_rdy = outstanding;
  assign r_resp_val   = outstanding && mem_resp_val && !owner;
  assign g_resp_val   = outstanding && mem_resp_val && owner;
  assign resp_data    = mem_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
      owner       <= 1'b0;
      locked      <= 1'b0;
    end else begin
      if (mem_req_go) begin
        outstanding <= 1'b1;
        owner       <= sel_g;
        locked      <= 1'b0;
      end else if (mem_req_val) begin
        // stalled, keep the same requester on the port
        owner  <= sel_g;
        locked <= 1'b1;
      end else if (outstanding && mem_resp_val) begin
        outstanding <= 1'b0;
      end
    end
  end

endmodule

/* pagerank_pkg.sv */
/*
  pagerank operand scheduler shared definitions
  sizes, host register map, bus structs and the memory word view
*/
package pagerank_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // one rank or matrix entry
  localparam int nbits = 8;

  // memory word
  localparam int bw = 32;

  // vector length
  localparam int n = 8;

  // entries packed into one memory word
  localparam int entries_per_word = bw / nbits;

  // words needed to hold all of R
  localparam int r_words = n * nbits / bw;

  // byte step from one G column to the next
  localparam int g_column_stride = n;

  // ----------------------------------------
  // host register map
  // ----------------------------------------

  localparam logic [31:0] addr_go     = 32'd0;
  localparam logic [31:0] addr_base_g = 32'd1;
  localparam logic [31:0] addr_base_r = 32'd2;
  localparam logic [31:0] addr_size   = 32'd3;
  localparam logic [31:0] addr_r_lo   = 32'd4;
  localparam logic [31:0] addr_r_hi   = 32'd5;
  localparam logic [31:0] addr_g_col  = 32'd6;

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef logic [nbits-1:0] entry_t;

  // memory word, whole or split per entry
  // entry 0 sits in the low byte
  typedef union packed {
    logic [bw-1:0]                     word;
    entry_t [entries_per_word-1:0]     entries;
  } mem_word_u;

  // host request, write high for a store
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
  } host_req_t;

  // host response, echoes the request kind
  typedef struct packed {
    logic        write;
    logic [31:0] data;
  } host_resp_t;

  // run configuration
  typedef struct packed {
    logic [31:0] base_g;
    logic [31:0] base_r;
    logic [31:0] size;
  } sched_cfg_t;

  // loaded rank vector, entry 0 lowest
  typedef entry_t [n-1:0] r_vec_t;

endpackage

/* pagerank_scheduler.sv */
/*
  pagerank operand scheduler top level
  host registers and two loaders sharing one memory port
*/
`timescale 1ns/100ps

module pagerank_scheduler import pagerank_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // host port
  input  host_req_t   pr_req,
  input  logic        pr_req_val,
  output logic        pr_req_rdy,
  output host_resp_t  pr_resp,
  output logic        pr_resp_val,
  input  logic        pr_resp_rdy,

  // memory port
  output logic [31:0] mem_req_addr,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,
  input  mem_word_u   mem_resp_data,
  input  logic        mem_resp_val,
  output logic        mem_resp_rdy
);

  sched_cfg_t  cfg;
  logic        start;

  // ----------------------------------------
  // loader side nets
  // ----------------------------------------

  logic        r_busy;
  logic        r_req_val;
  logic [31:0] r_req_addr;
  logic        r_req_rdy;
  logic        r_resp_val;
  r_vec_t      r_vec;

  logic        g_busy;
  logic        g_req_val;
  logic [31:0] g_req_addr;
  logic        g_req_rdy;
  logic        g_resp_val;
  mem_word_u   g_col;

  // one response word feeds both loaders
  mem_word_u   resp_data;

  host_regs u_host_regs (
    .clk         (clk),
    .reset       (reset),
    .pr_req      (pr_req),
    .pr_req_val  (pr_req_val),
    .pr_req_rdy  (pr_req_rdy),
    .pr_resp     (pr_resp),
    .pr_resp_val (pr_resp_val),
    .pr_resp_rdy (pr_resp_rdy),
    .r_busy      (r_busy),
    .g_busy      (g_busy),
    .r_vec       (r_vec),
    .g_col       (g_col),
    .cfg         (cfg),
    .start       (start)
  );

  r_loader u_r_loader (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .base_r    (cfg.base_r),
    .busy      (r_busy),
    .req_val   (r_req_val),
    .req_addr  (r_req_addr),
    .req_rdy   (r_req_rdy),
    .resp_val  (r_resp_val),
    .resp_data (resp_data),
    .r_vec     (r_vec)
  );

  g_loader u_g_loader (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .base_g    (cfg.base_g),
    .size      (cfg.size),
    .busy      (g_busy),
    .req_val   (g_req_val),
    .req_addr  (g_req_addr),
    .req_rdy   (g_req_rdy),
    .resp_val  (g_resp_val),
    .resp_data (resp_data),
    .g_col     (g_col)
  );

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .reset         (reset),
    .r_req_val     (r_req_val),
    .r_req_addr    (r_req_addr),
    .r_req_rdy     (r_req_rdy),
    .r_resp_val    (r_resp_val),
    .g_req_val     (g_req_val),
    .g_req_addr    (g_req_addr),
    .g_req_rdy     (g_req_rdy),
    .g_resp_val    (g_resp_val),
    .resp_data     (resp_data),
    .mem_req_val   (mem_req_val),
    .mem_req_addr  (mem_req_addr),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_data (mem_resp_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy)
  );

endmodule

/* pagerank_scheduler_asserts.sv */
/*
  protocol checks bound into the pagerank scheduler top level
  memory request hold, single outstanding request, host response, reset state
*/
`timescale 1ns/100ps

module pagerank_scheduler_asserts (
  input logic        clk,
  input logic        reset,
  input logic        pr_req_val,
  input logic        pr_resp_val,
  input logic [31:0] mem_req_addr,
  input logic        mem_req_val,
  input logic        mem_req_rdy,
  input logic        mem_resp_val,
  input logic        mem_resp_rdy
);

  // failures so far, read by the testbench at the end
  int unsigned fail_count = 0;
  // memory request taken, response not yet back
  logic        in_flight;
  // reset seen on the previous edge
  logic        past_reset = 1'b0;

  always @(posedge clk) begin
    past_reset <= reset;
  end

  // ----------------------------------------
  // outstanding request tracker
  // ----------------------------------------

  always @(posedge clk) begin
    if (reset)
      in_flight <= 1'b0;
    else if (mem_req_val && mem_req_rdy)
      in_flight <= 1'b1;
    else if (mem_resp_val && mem_resp_rdy)
      in_flight <= 1'b0;
  end

  // ----------------------------------------
  // properties
  // ----------------------------------------

  // stalled request keeps valid and address
  addr_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_addr))
  else begin
    fail_count++;
    $error("memory request dropped or changed its address while stalled");
  end

  // one request in flight at most
  single_outstanding: assert property (@(posedge clk) disable iff (reset)
    in_flight |-> !mem_req_val)
  else begin
    fail_count++;
    $error("new memory request while a response is outstanding");
  end

  // a response only ever answers a request
  resp_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(pr_resp_val) |-> pr_req_val)
  else begin
    fail_count++;
    $error("host response valid rose without a host request");
  end

  // first edge skipped, state is unknown before it
  quiet_in_reset: assert property (@(posedge clk)
    reset && past_reset |-> !mem_req_val && !mem_resp_rdy && !pr_resp_val)
  else begin
    fail_count++;
    $error("memory or host handshake active during reset");
  end

endmodule

bind pagerank_scheduler pagerank_scheduler_asserts protocol_checks (
  .clk          (clk),
  .reset        (reset),
  .pr_req_val   (pr_req_val),
  .pr_resp_val  (pr_resp_val),
  .mem_req_addr (mem_req_addr),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_resp_val (mem_resp_val),
  .mem_resp_rdy (mem_resp_rdy)
);

/* r_loader.sv */
/*
  rank vector loader
  reads r_words memory words from base_r and spreads them over the R bank
*/
`timescale 1ns/100ps

module r_loader import pagerank_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] base_r,

  // toward the arbiter
  output logic        busy,
  output logic        req_val,
  output logic [31:0] req_addr,
  input  logic        req_rdy,
  input  logic        resp_val,
  input  mem_word_u   resp_data,

  output r_vec_t      r_vec
);

  logic                       waiting;
  logic [$clog2(r_words)-1:0] word_cnt;
  logic                       last_word;

  // request while busy and nothing in flight
  assign req_val  = busy && !waiting;
  assign req_addr = base_r + 32'(word_cnt) * (bw / 8);

  assign last_word = (word_cnt == r_words - 1);

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      waiting  <= 1'b0;
      word_cnt <= '0;
    end else if (start && !busy) begin
      busy     <= 1'b1;
      waiting  <= 1'b0;
      word_cnt <= '0;
    end else if (busy) begin
      if (!waiting && req_rdy) begin
        waiting <= 1'b1;
      end else if (waiting && resp_val) begin
        waiting <= 1'b0;
        // done once the final word is in
        if (last_word)
          busy <= 1'b0;
        else
          word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // R bank
  // ----------------------------------------

  // each word fills entries_per_word consecutive slots
  always_ff @(posedge clk) begin
    if (waiting && resp_val) begin
      for (int i = 0; i < entries_per_word; i++) begin
        r_vec[int'(word_cnt) * entries_per_word + i] <= resp_data.entries[i];
      end
    end
  end

endmodule

/* tb_pagerank_scheduler.sv */
/*
  testbench for the pagerank operand scheduler
  host register traffic, random memory latency and readback checks
*/
`timescale 1ns/100ps

module tb_pagerank_scheduler import pagerank_pkg::*; ();

  localparam int unsigned host_timeout = 2000;
  localparam int unsigned mem_timeout  = 50;
  // late in the cycle, after the falling edge drive has settled
  localparam int          sample_delay = 40;

  logic        clk;
  logic        reset;
  host_req_t   pr_req;
  logic        pr_req_val;
  logic        pr_req_rdy;
  host_resp_t  pr_resp;
  logic        pr_resp_val;
  logic        pr_resp_rdy;
  logic [31:0] mem_req_addr;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_word_u   mem_resp_data;
  logic        mem_resp_val;
  logic        mem_resp_rdy;

  int unsigned errors;
  int unsigned checks;
  // a host request never got through, remaining steps are skipped
  logic        timed_out;
  // accepted memory request addresses, filled by the memory model
  logic [31:0] seen_addrs[$];
  // G column expected in the DUT, kept across empty runs
  logic [31:0] last_g_col;

  pagerank_scheduler dut (
    .clk           (clk),
    .reset         (reset),
    .pr_req        (pr_req),
    .pr_req_val    (pr_req_val),
    .pr_req_rdy    (pr_req_rdy),
    .pr_resp       (pr_resp),
    .pr_resp_val   (pr_resp_val),
    .pr_resp_rdy   (pr_resp_rdy),
    .mem_req_addr  (mem_req_addr),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_data (mem_resp_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ----------------------------------------
  // memory contents and checks
  // ----------------------------------------

  // byte at a is the low address byte xor 5a
  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    return addr[7:0] ^ 8'h5a;
  endfunction

  // lowest byte first
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {mem_byte(addr + 32'd3), mem_byte(addr + 32'd2),
            mem_byte(addr + 32'd1), mem_byte(addr)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (!timed_out) begin
      checks++;
      assert (actual === expected)
      else begin
        errors++;
        $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      end
    end
  endtask

  // one seen request per expected address
  task automatic expect_request(input string name, input logic [31:0] addr);
    int found;
    found = -1;
    for (int i = 0; i < seen_addrs.size(); i++) begin
      if (found < 0 && seen_addrs[i] == addr)
        found = i;
    end
    if (!timed_out) begin
      checks++;
      assert (found >= 0)
      else begin
        errors++;
        $display("%s: no memory request was seen for address 0x%08h", name, addr);
      end
    end
    if (found >= 0)
      seen_addrs.delete(found);
  endtask

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = dut.protocol_checks.fail_count;
    $display("checks %0d, errors %0d, protocol assertion failures %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------

  task automatic serve_memory();
    logic        pending;
    logic [31:0] addr;
    int unsigned delay;
    int unsigned held;
    logic        req_rdy_next;
    pending      = 1'b0;
    addr         = 32'd0;
    delay        = 0;
    held         = 0;
    req_rdy_next = 1'b0;
    forever begin
      @(negedge clk);
      mem_req_rdy  = req_rdy_next;
      mem_resp_val = 1'b0;
      if (pending && delay != 0) begin
        delay--;
      end else if (pending) begin
        mem_resp_val       = 1'b1;
        mem_resp_data.word = mem_word(addr);
        held++;
        if (held > mem_timeout) begin
          errors++;
          $display("memory response for address 0x%08h was never taken", addr);
          pending = 1'b0;
        end
      end
      // handshakes seen just before the rising edge
      #(sample_delay);
      if (!reset) begin
        if (mem_resp_val && mem_resp_rdy)
          pending = 1'b0;
        if (mem_req_val && mem_req_rdy) begin
          pending = 1'b1;
          addr    = mem_req_addr;
          delay   = $urandom_range(5);
          held    = 0;
          seen_addrs.push_back(mem_req_addr);
        end
      end
      // random stalls on the request side
      req_rdy_next = ($urandom_range(3) != 0);
    end
  endtask

  // ----------------------------------------
  // host side
  // ----------------------------------------

  // gap is the number of cycles the host holds its response ready low
  task automatic host_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input int unsigned gap,
                             output logic [31:0] rdata, output int unsigned waited);
    logic done;
    done   = 1'b0;
    waited = 0;
    rdata  = 32'd0;
    if (!timed_out) begin
      @(negedge clk);
      pr_req.write = write;
      pr_req.addr  = addr;
      pr_req.data  = data;
      pr_req_val   = 1'b1;
      pr_resp_rdy  = (gap == 0);
      while (!done && waited < host_timeout) begin
        #(sample_delay);
        if (pr_req_rdy) begin
          done  = 1'b1;
          rdata = pr_resp.data;
          check_value("response valid on accept", 32'd1, 32'(pr_resp_val));
          check_value("response kind", 32'(write), 32'(pr_resp.write));
        end else begin
          @(negedge clk);
          waited++;
          if (waited >= gap)
            pr_resp_rdy = 1'b1;
        end
      end
      if (!done) begin
        errors++;
        $display("host request to address 0x%08h not accepted within %0d cycles",
                 addr, host_timeout);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
        pr_req_val  = 1'b0;
        pr_resp_rdy = 1'b0;
      end
    end
  endtask

  task automatic write_reg(input string name, input logic [31:0] addr,
                           input logic [31:0] data);
    logic [31:0] rdata;
    int unsigned waited;
    host_access(1'b1, addr, data, $urandom_range(2), rdata, waited);
    check_value({name, " write response"}, 32'd0, rdata);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    int unsigned waited;
    host_access(1'b0, addr, 32'd0, $urandom_range(2), rdata, waited);
    check_value(name, expected, rdata);
  endtask

  // configure, start, then read everything back
  task automatic run_check(input string name, input logic [31:0] base_g,
                           input logic [31:0] base_r, input logic [31:0] size);
    logic [31:0] rdata;
    int unsigned waited;
    write_reg({name, " base_g"}, addr_base_g, base_g);
    write_reg({name, " base_r"}, addr_base_r, base_r);
    write_reg({name, " size"}, addr_size, size);
    read_check({name, " base_g readback"}, addr_base_g, base_g);
    read_check({name, " base_r readback"}, addr_base_r, base_r);
    read_check({name, " size readback"}, addr_size, size);
    seen_addrs.delete();
    write_reg({name, " go"}, addr_go, 32'd0);
    // ready held from the start, so any wait is back-pressure
    host_access(1'b0, addr_r_lo, 32'd0, 0, rdata, waited);
    check_value({name, " request held while busy"}, 32'd1, 32'(waited > 0));
    check_value({name, " R word 0"}, mem_word(base_r), rdata);
    read_check({name, " R word 1"}, addr_r_hi, mem_word(base_r + 32'd4));
    if (size != 0)
      last_g_col = mem_word(base_g + (size - 32'd1) * 32'(n));
    read_check({name, " G column"}, addr_g_col, last_g_col);
    // each R word and G column fetched exactly once
    for (int k = 0; k < r_words; k++)
      expect_request({name, " R request"}, base_r + 32'(k) * 32'd4);
    for (int unsigned c = 0; c < size; c++)
      expect_request({name, " G request"}, base_g + c * 32'(n));
    check_value({name, " extra memory requests"}, 32'd0, 32'(seen_addrs.size()));
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin : stimulus
    logic [31:0] base_g;
    logic [31:0] base_r;
    logic [31:0] size;
    void'($urandom(32'hdeac_3beb));
    reset         = 1'b1;
    pr_req        = '0;
    pr_req_val    = 1'b0;
    pr_resp_rdy   = 1'b0;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    last_g_col    = 32'd0;
    // memory thread inherits its seed from this one
    fork
      serve_memory();
    join_none
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset       = 1'b0;
    pr_resp_rdy = 1'b1;
    #(sample_delay);
    // idle after reset, ready follows the host response ready
    check_value("ready follows response ready", 32'd1, 32'(pr_req_rdy));
    check_value("no response without request", 32'd0, 32'(pr_resp_val));
    check_value("no memory request after reset", 32'd0, 32'(mem_req_val));
    check_value("no memory response ready after reset", 32'd0, 32'(mem_resp_rdy));
    @(negedge clk);
    pr_resp_rdy = 1'b0;
    #(sample_delay);
    check_value("ready low with response ready low", 32'd0, 32'(pr_req_rdy));

    run_check("first run", 32'h0000_0100, 32'h0000_0040, 32'd3);
    // G column must survive a run without columns
    run_check("empty run", 32'h0000_0800, 32'h0000_0020, 32'd0);

    for (int i = 0; i < 5; i++) begin
      base_g = $urandom;
      base_r = $urandom;
      size   = $urandom_range(1, 6);
      run_check("random run", base_g, base_r, size);
    end

    read_check("unmapped address 7", 32'd7, 32'd0);
    read_check("unmapped high address", 32'hdead_0010, 32'd0);
    finish_run();
  end

endmodule
